//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mbxCtlTb
FLIST    = flist.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ)/V$(TOP): $(FLIST) $(wildcard src/*.sv src/*.svh tests/*.sv)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

test: $(OBJ)/V$(TOP)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- flist.f
+incdir+src
src/mbxPkg.sv
src/mbWordTracker.sv
src/mbReqSelect.sv
src/cacheToMbSeq.sv
src/mbDiagMux.sv
src/mbxCtl.sv
tests/tbClock.sv
tests/mbxCtlTb.sv

//--- src/cacheToMbSeq.sv
// Four fixed steps per writeback block; a new block is taken only from idle
`timescale 1ns/1ps

module cacheToMbSeq (
  input  logic               clk,
  input  logic               arstN,
  input  logic               wbValid,
  input  mbxPkg::mbWordMaskT wbMask,
  output logic               wbReady,
  output logic               xferLoad,
  output mbxPkg::mbWordMaskT xferMask,
  output mbxPkg::xferStateE  xferState
);
  import mbxPkg::*;

  logic      wbAccept;
  xferStateE nextState;

  assign wbReady  = (xferState == xferIdle);
  assign wbAccept = wbValid & wbReady;

  // Block words reach the MB in the last step
  assign xferLoad = (xferState == xferT4);

  ////////////////////////////////////////
  // T1 to T4 chain
  ////////////////////////////////////////

  always_comb begin
    nextState = xferState;
    unique case (xferState)
      xferIdle: begin
        if (wbValid) begin
          nextState = xferT1;
        end
      end
      xferT1:  nextState = xferT2;
      xferT2:  nextState = xferT3;
      xferT3:  nextState = xferT4;
      xferT4:  nextState = xferIdle;
      default: nextState = xferIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      xferState <= xferIdle;
    end else begin
      xferState <= nextState;
    end
  end

  // Mask of words in the block, held for the whole sequence
  always_ff @(posedge clk) begin
    if (wbAccept) begin
      xferMask <= wbMask;
    end
  end

  // Accepted block is loaded exactly four edges later
  loadAfterAccept: assert property (
    @(posedge clk) disable iff (!arstN)
    wbAccept |-> ##4 (xferLoad && xferState == xferT4)
  );

endmodule

//--- src/mbDiagMux.sv
// Purely combinational status read; codes above diagMemReq return zero
`timescale 1ns/1ps
`include "mbx_defines.svh"

module mbDiagMux (
  input  logic [`DIAG_SEL_W-1:0] diagSel,
  input  mbxPkg::mbWordMaskT     wrPend,
  input  mbxPkg::mbWordMaskT     rdPend,
  input  mbxPkg::xferStateE      xferState,
  input  logic                   memValid,
  input  mbxPkg::memOpE          memOp,
  input  mbxPkg::mbWordIdxT      memWord,
  output logic [`DIAG_W-1:0]     diagData
);
  import mbxPkg::*;

  logic [`DIAG_W-1:0] xferOneHot;

  // Bit 0 is T1, bit 3 is T4, idle reads zero
  always_comb begin
    xferOneHot = '0;
    case (xferState)
      xferT1:  xferOneHot[0] = 1'b1;
      xferT2:  xferOneHot[1] = 1'b1;
      xferT3:  xferOneHot[2] = 1'b1;
      xferT4:  xferOneHot[3] = 1'b1;
      default: xferOneHot = '0;
    endcase
  end

  ////////////////////////////////////////
  // Function code decode
  ////////////////////////////////////////

  always_comb begin
    case (diagSelE'(diagSel))
      diagWrPend: diagData = wrPend;
      diagRdPend: diagData = rdPend;
      diagXfer:   diagData = xferOneHot;
      // Valid on top, then write flag, then word
      diagMemReq: diagData = {memValid, memOp == memWrite, memWord};
      default:    diagData = '0;
    endcase
  end

endmodule

//--- src/mbReqSelect.sv
// One request at a time, reads before writes and lowest word first; held until memReady
`timescale 1ns/1ps
`include "mbx_defines.svh"

module mbReqSelect (
  input  logic               clk,
  input  logic               arstN,
  input  mbxPkg::mbWordMaskT wrPend,
  input  mbxPkg::mbWordMaskT rdPend,
  input  logic               memReady,
  output logic               memValid,
  output mbxPkg::memOpE      memOp,
  output mbxPkg::mbWordIdxT  memWord
);
  import mbxPkg::*;

  logic       memAccept;
  logic       reqHold;
  logic       nextValid;
  memOpE      nextOp;
  mbWordIdxT  nextWord;
  mbWordMaskT doneBit;
  mbWordMaskT wrAvail;
  mbWordMaskT rdAvail;
  mbWordMaskT pickMask;

  assign memAccept = memValid & memReady;
  assign reqHold   = memValid & ~memReady;

  // The word being accepted is still set in the tracker this cycle
  assign doneBit = memAccept ? (mbWordMaskT'(1) << memWord) : '0;
  assign wrAvail = (memOp == memWrite) ? (wrPend & ~doneBit) : wrPend;
  assign rdAvail = (memOp == memRead) ? (rdPend & ~doneBit) : rdPend;

  assign nextOp    = (rdAvail == '0 && wrAvail != '0) ? memWrite : memRead;
  assign pickMask  = (nextOp == memRead) ? rdAvail : wrAvail;
  assign nextValid = |pickMask;

  // Lowest set index wins
  always_comb begin
    nextWord = '0;
    for (int i = `MB_WORDS - 1; i >= 0; i--) begin
      if (pickMask[i]) begin
        nextWord = mbWordIdxT'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memValid <= 1'b0;
      memOp    <= memRead;
      memWord  <= '0;
    end else if (!reqHold) begin
      memValid <= nextValid;
      memOp    <= nextOp;
      memWord  <= nextWord;
    end
  end

  // Request stays put under back-pressure
  reqStable: assert property (
    @(posedge clk) disable iff (!arstN)
    reqHold |=> memValid && $stable(memOp) && $stable(memWord)
  );

endmodule

//--- src/mbWordTracker.sv
// Pending bits only, no data storage; a refill is taken only when no read is outstanding
`timescale 1ns/1ps

module mbWordTracker (
  input  logic               clk,
  input  logic               arstN,
  input  logic               coreWrValid,
  input  mbxPkg::mbWordIdxT  coreWrWord,
  input  logic               xferLoad,
  input  mbxPkg::mbWordMaskT xferMask,
  input  logic               rdValid,
  input  mbxPkg::mbWordMaskT rdValidMask,
  input  logic               memValid,
  input  logic               memReady,
  input  mbxPkg::memOpE      memOp,
  input  mbxPkg::mbWordIdxT  memWord,
  output logic               coreWrReady,
  output logic               rdReady,
  output mbxPkg::mbWordMaskT wrPend,
  output mbxPkg::mbWordMaskT rdPend
);
  import mbxPkg::*;

  logic       memAccept;
  mbWordMaskT coreWrBit;
  mbWordMaskT memBit;
  mbWordMaskT wrSet;
  mbWordMaskT wrClr;
  mbWordMaskT rdSet;
  mbWordMaskT rdClr;

  // Core writes wait while the writeback block lands in the MB
  assign coreWrReady = ~xferLoad;
  assign rdReady     = ~|rdPend;
  assign memAccept   = memValid & memReady;

  assign coreWrBit = mbWordMaskT'(1) << coreWrWord;
  assign memBit    = mbWordMaskT'(1) << memWord;

  ////////////////////////////////////////
  // Set and clear terms
  ////////////////////////////////////////

  assign wrSet = ((coreWrValid && coreWrReady) ? coreWrBit : '0) |
                 (xferLoad ? xferMask : '0);
  assign wrClr = (memAccept && memOp == memWrite) ? memBit : '0;

  // Ask for every word the cache does not already hold
  assign rdSet = (rdValid && rdReady) ? ~rdValidMask : '0;
  assign rdClr = (memAccept && memOp == memRead) ? memBit : '0;

  // A new set in the clearing cycle keeps the word pending
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPend <= '0;
      rdPend <= '0;
    end else begin
      wrPend <= (wrPend & ~wrClr) | wrSet;
      rdPend <= (rdPend & ~rdClr) | rdSet;
    end
  end

  // Selector never offers a word that is not pending here
  acceptWasPending: assert property (
    @(posedge clk) disable iff (!arstN)
    memAccept |-> ((memOp == memWrite) ? wrPend[memWord] : rdPend[memWord])
  );

endmodule

//--- src/mbxCtl.sv
// MB control top; all handshakes are valid/ready and no buffer data passes through here
`timescale 1ns/1ps
`include "mbx_defines.svh"

module mbxCtl (
  input  logic                   clk,
  input  logic                   arstN,
  // Core single-word write
  input  logic                   coreWrValid,
  input  mbxPkg::mbWordIdxT      coreWrWord,
  output logic                   coreWrReady,
  // Cache writeback block
  input  logic                   wbValid,
  input  mbxPkg::mbWordMaskT     wbMask,
  output logic                   wbReady,
  // Cache refill read
  input  logic                   rdValid,
  input  mbxPkg::mbWordMaskT     rdValidMask,
  output logic                   rdReady,
  // Memory request
  output logic                   memValid,
  output mbxPkg::memOpE          memOp,
  output mbxPkg::mbWordIdxT      memWord,
  input  logic                   memReady,
  // Diagnostics
  input  logic [`DIAG_SEL_W-1:0] diagSel,
  output logic [`DIAG_W-1:0]     diagData
);
  import mbxPkg::*;

  logic       xferLoad;
  mbWordMaskT xferMask;
  xferStateE  xferState;
  mbWordMaskT wrPend;
  mbWordMaskT rdPend;

  cacheToMbSeq uSeq (
    .clk       (clk),
    .arstN     (arstN),
    .wbValid   (wbValid),
    .wbMask    (wbMask),
    .wbReady   (wbReady),
    .xferLoad  (xferLoad),
    .xferMask  (xferMask),
    .xferState (xferState)
  );

  mbWordTracker uTracker (
    .clk         (clk),
    .arstN       (arstN),
    .coreWrValid (coreWrValid),
    .coreWrWord  (coreWrWord),
    .xferLoad    (xferLoad),
    .xferMask    (xferMask),
    .rdValid     (rdValid),
    .rdValidMask (rdValidMask),
    .memValid    (memValid),
    .memReady    (memReady),
    .memOp       (memOp),
    .memWord     (memWord),
    .coreWrReady (coreWrReady),
    .rdReady     (rdReady),
    .wrPend      (wrPend),
    .rdPend      (rdPend)
  );

  mbReqSelect uSelect (
    .clk      (clk),
    .arstN    (arstN),
    .wrPend   (wrPend),
    .rdPend   (rdPend),
    .memReady (memReady),
    .memValid (memValid),
    .memOp    (memOp),
    .memWord  (memWord)
  );

  mbDiagMux uDiag (
    .diagSel   (diagSel),
    .wrPend    (wrPend),
    .rdPend    (rdPend),
    .xferState (xferState),
    .memValid  (memValid),
    .memOp     (memOp),
    .memWord   (memWord),
    .diagData  (diagData)
  );

endmodule

//--- src/mbxPkg.sv
// Shared types for the memory buffer control, sized by the macros in mbx_defines.svh
`include "mbx_defines.svh"

package mbxPkg;

  // One bit per buffer word, bit 0 is word 0
  typedef logic [`MB_WORDS-1:0] mbWordMaskT;

  // Index of a single buffer word
  typedef logic [`MB_IDX_W-1:0] mbWordIdxT;

  // Memory operation issued with a request
  typedef enum logic {
    memRead  = 1'b0,
    memWrite = 1'b1
  } memOpE;

  // Cache to MB transfer steps
  typedef enum logic [2:0] {
    xferIdle,
    xferT1,
    xferT2,
    xferT3,
    xferT4
  } xferStateE;

  // Diagnostic function codes, unlisted codes read as zero
  typedef enum logic [`DIAG_SEL_W-1:0] {
    diagWrPend = 3'd0,
    diagRdPend = 3'd1,
    diagXfer   = 3'd2,
    diagMemReq = 3'd3
  } diagSelE;

endpackage

//--- src/mbx_defines.svh
// Sizes are fixed for a four-word buffer and the RTL does not scale if these change
`ifndef MBX_DEFINES_SVH
`define MBX_DEFINES_SVH

////////////////////////////////////////
// Memory buffer geometry
////////////////////////////////////////

// Words held in the memory buffer
`define MB_WORDS 4
// Bits needed to address one buffer word
`define MB_IDX_W 2

////////////////////////////////////////
// Diagnostic read path
////////////////////////////////////////
`define DIAG_SEL_W 3
`define DIAG_W 4

`endif

//--- tests/mbxCtlTb.sv
// Directed tests with a cycle model of the pending masks; stops at the first mismatch
`timescale 1ns/1ps
`include "mbx_defines.svh"

module mbxCtlTb;
  import mbxPkg::*;

  logic                   clk;
  logic                   arstN;
  logic                   coreWrValid;
  mbWordIdxT              coreWrWord;
  logic                   coreWrReady;
  logic                   wbValid;
  mbWordMaskT             wbMask;
  logic                   wbReady;
  logic                   rdValid;
  mbWordMaskT             rdValidMask;
  logic                   rdReady;
  logic                   memValid;
  memOpE                  memOp;
  mbWordIdxT              memWord;
  logic                   memReady;
  logic [`DIAG_SEL_W-1:0] diagSel;
  logic [`DIAG_W-1:0]     diagData;

  // Reference model state
  mbWordMaskT mWr;
  mbWordMaskT mRd;
  logic       mValid;
  logic       mOp;
  mbWordIdxT  mWord;
  int         mState;
  mbWordMaskT mMask;

  // Accepted requests in order with op 1 for a write
  logic       issuedOp[$];
  mbWordIdxT  issuedWord[$];

  logic [31:0] lfsr = 32'h1b3e;
  int          cycles = 0;

  tbClock clkGen (.clk(clk), .arstN(arstN));

  mbxCtl UUT (
    .clk(clk), .arstN(arstN),
    .coreWrValid(coreWrValid), .coreWrWord(coreWrWord), .coreWrReady(coreWrReady),
    .wbValid(wbValid), .wbMask(wbMask), .wbReady(wbReady),
    .rdValid(rdValid), .rdValidMask(rdValidMask), .rdReady(rdReady),
    .memValid(memValid), .memOp(memOp), .memWord(memWord), .memReady(memReady),
    .diagSel(diagSel), .diagData(diagData)
  );

  task automatic stopRun(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "stopped after first error");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic mbWordIdxT lowestBit(input mbWordMaskT m);
    mbWordIdxT idx;
    logic      found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < `MB_WORDS; i++) begin
      if (m[i] && !found) begin
        idx = mbWordIdxT'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////
  // Model and cycle checks
  ////////////////////////////////////////

  always @(posedge clk or negedge arstN) begin
    logic       acc;
    mbWordMaskT accBit;
    mbWordMaskT wrSet;
    mbWordMaskT rdSet;
    mbWordMaskT wrAvail;
    mbWordMaskT rdAvail;
    if (!arstN) begin
      mWr = '0;
      mRd = '0;
      mValid = 1'b0;
      mOp = 1'b0;
      mWord = '0;
      mState = 0;
      mMask = '0;
    end else begin
      assert (memValid == mValid && (!mValid || (memOp == memOpE'(mOp) && memWord == mWord)))
        else stopRun($sformatf("FAIL %0t: request %0b/%0d/%0d, expected %0b/%0d/%0d",
                               $time, memValid, memOp, memWord, mValid, mOp, mWord));
      assert (wbReady == (mState == 0) && rdReady == (mRd == '0) &&
              coreWrReady == (mState != 4))
        else stopRun($sformatf("FAIL %0t: ready flags wb %0b rd %0b core %0b",
                               $time, wbReady, rdReady, coreWrReady));
      acc = mValid && memReady;
      accBit = acc ? (mbWordMaskT'(1) << mWord) : '0;
      if (acc) begin
        issuedOp.push_back(mOp);
        issuedWord.push_back(mWord);
      end
      wrSet = (coreWrValid && mState != 4) ? (mbWordMaskT'(1) << coreWrWord) : '0;
      if (mState == 4) begin
        wrSet = wrSet | mMask;
      end
      rdSet = (rdValid && mRd == '0) ? ~rdValidMask : '0;
      // Selector picks from the masks seen before this edge
      if (!(mValid && !memReady)) begin
        wrAvail = mOp ? (mWr & ~accBit) : mWr;
        rdAvail = mOp ? mRd : (mRd & ~accBit);
        mValid = (rdAvail | wrAvail) != '0;
        mOp = (rdAvail == '0 && wrAvail != '0);
        mWord = lowestBit(mOp ? wrAvail : rdAvail);
      end
      mWr = ((mWr & ~((acc && issuedOp[$]) ? accBit : '0)) | wrSet);
      mRd = ((mRd & ~((acc && !issuedOp[$]) ? accBit : '0)) | rdSet);
      if (mState == 0 && wbValid) begin
        mMask = wbMask;
        mState = 1;
      end else if (mState != 0) begin
        mState = (mState == 4) ? 0 : mState + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= 3000) begin
      stopRun("Timeout: the tests did not finish within 3000 cycles");
    end
  end

  // Lets the DUT empty both pending masks
  task automatic drainAll(input logic randomReady);
    while (mWr != '0 || mRd != '0 || mValid || mState != 0) begin
      memReady = randomReady ? 1'(randBits(1)) : 1'b1;
      nextCycle();
    end
    memReady = 1'b1;
  endtask

  task automatic coreWrite(input mbWordIdxT word);
    coreWrValid = 1'b1;
    coreWrWord = word;
    nextCycle();
    coreWrValid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testReset();
    assert (!memValid && wbReady && rdReady && coreWrReady)
      else stopRun($sformatf("FAIL %0t: outputs after reset are wrong", $time));
    for (int s = 0; s < 8; s++) begin
      diagSel = s[`DIAG_SEL_W-1:0];
      #1;
      assert (diagData == '0)
        else stopRun($sformatf("FAIL %0t: diag code %0d reads %h after reset",
                               $time, s, diagData));
      nextCycle();
    end
    diagSel = diagWrPend;
  endtask

  // A held read keeps the selector busy so both writes are pending together
  task automatic testCoreWrites();
    int base;
    base = issuedOp.size();
    diagSel = diagWrPend;
    memReady = 1'b0;
    rdValid = 1'b1;
    rdValidMask = 4'b1110;
    nextCycle();
    rdValid = 1'b0;
    coreWrite(2);
    coreWrite(0);
    drainAll(1'b0);
    assert (issuedOp.size() == base + 3 && issuedOp[base + 1] && issuedWord[base + 1] == 0 &&
            issuedOp[base + 2] && issuedWord[base + 2] == 2)
      else stopRun($sformatf("FAIL %0t: core writes issued out of order", $time));
    assert (diagData == '0)
      else stopRun($sformatf("FAIL %0t: write-pending reads %h", $time, diagData));
  endtask

  task automatic testWritebacks();
    mbWordMaskT mask;
    int         base;
    int         k;
    for (int n = 0; n < 6; n++) begin
      mask = mbWordMaskT'(randBits(4));
      if (mask == '0) begin
        mask = 4'b1000;
      end
      base = issuedOp.size();
      wbValid = 1'b1;
      wbMask = mask;
      nextCycle();
      wbValid = 1'b0;
      diagSel = diagXfer;
      for (int j = 0; j < 4; j++) begin
        memReady = 1'(randBits(1));
        #1;
        assert (diagData == (4'b0001 << j) && !wbReady)
          else stopRun($sformatf("FAIL %0t: step %0d diag %b wbReady %0b",
                                 $time, j + 1, diagData, wbReady));
        nextCycle();
      end
      drainAll(1'b1);
      k = base;
      for (int i = 0; i < `MB_WORDS; i++) begin
        if (mask[i]) begin
          assert (k < issuedOp.size() && issuedOp[k] && issuedWord[k] == mbWordIdxT'(i))
            else stopRun($sformatf("FAIL %0t: mask %b not issued in order", $time, mask));
          k++;
        end
      end
    end
  endtask

  task automatic testRefillPriority();
    mbWordMaskT valid;
    int         base;
    int         nRd;
    for (int n = 0; n < 4; n++) begin
      base = issuedOp.size();
      memReady = 1'b0;
      coreWrite(1);
      coreWrite(3);
      valid = mbWordMaskT'(randBits(4)) & 4'b0111;
      nRd = $countones(~valid);
      rdValid = 1'b1;
      rdValidMask = valid;
      nextCycle();
      rdValid = 1'b0;
      drainAll(1'b0);
      // First entry is the write that was already held
      for (int i = 1; i < issuedOp.size() - base; i++) begin
        assert (issuedOp[base + i] == (i > nRd))
          else stopRun($sformatf("FAIL %0t: write issued before refill reads", $time));
      end
    end
  endtask

  task automatic testHold();
    memOpE     heldOp;
    mbWordIdxT heldWord;
    memReady = 1'b0;
    coreWrite(3);
    while (!memValid) begin
      nextCycle();
    end
    // Word 3 is the only pending word when the request goes out
    heldOp = memWrite;
    heldWord = 2'd3;
    diagSel = diagMemReq;
    rdValid = 1'b1;
    rdValidMask = 4'b0000;
    for (int i = 0; i < 20; i++) begin
      coreWrValid = 1'b1;
      coreWrWord = mbWordIdxT'(randBits(2));
      #1;
      assert (memValid && memOp == heldOp && memWord == heldWord &&
              diagData == {1'b1, 1'b1, heldWord})
        else stopRun($sformatf("FAIL %0t: held request changed", $time));
      nextCycle();
      rdValid = 1'b0;
    end
    coreWrValid = 1'b0;
    drainAll(1'b0);
  endtask

  task automatic testMixed();
    for (int i = 0; i < 200; i++) begin
      coreWrValid = 1'(randBits(1));
      coreWrWord = mbWordIdxT'(randBits(2));
      wbValid = (randBits(3) == 0);
      wbMask = mbWordMaskT'(randBits(4));
      rdValid = (randBits(3) == 0);
      rdValidMask = mbWordMaskT'(randBits(4));
      memReady = 1'(randBits(1));
      nextCycle();
    end
    coreWrValid = 1'b0;
    wbValid = 1'b0;
    rdValid = 1'b0;
    drainAll(1'b1);
    diagSel = diagWrPend;
    #1;
    assert (diagData == '0)
      else stopRun($sformatf("FAIL %0t: write-pending left %h", $time, diagData));
    nextCycle();
    diagSel = diagRdPend;
    #1;
    assert (diagData == '0)
      else stopRun($sformatf("FAIL %0t: read-pending left %h", $time, diagData));
  endtask

  initial begin
    coreWrValid = 1'b0;
    coreWrWord = '0;
    wbValid = 1'b0;
    wbMask = '0;
    rdValid = 1'b0;
    rdValidMask = '0;
    memReady = 1'b1;
    diagSel = '0;
    wait (arstN);
    nextCycle();
    testReset();
    testCoreWrites();
    testWritebacks();
    testRefillPriority();
    testHold();
    testMixed();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- tests/tbClock.sv
// Free-running 10 ns clock; reset is held low for the first 5 rising edges
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;
  end

endmodule
